// ==== src/vae_pkg.sv ====
`default_nettype none

package vae_pkg;

    // Q8.8 fixed point
    localparam int FRAC_BITS = 8;            // Binary point position
    typedef logic signed [15:0] fix_t;       // Sample, weight or bias
    typedef logic signed [31:0] acc_t;       // Full precision running sum

    // Network shape
    localparam int N_IN  = 9;                // Inputs, also decoded outputs
    localparam int N_LAT = 2;                // Mean branch latents

    // Memory geometry
    localparam int WT_ROWS   = 18;           // Layer-2 rows then layer-3 rows
    localparam int WT_ADDR_W = 5;
    localparam int X_ADDR_W  = 4;            // Input and output memories
    localparam int WT_BE_W   = 8;            // One enable per weight row byte
    localparam int X_BE_W    = 2;

    // Row marks used by the sequencer
    localparam logic [WT_ADDR_W-1:0] L3_BASE     = WT_ADDR_W'(N_IN);
    localparam logic [WT_ADDR_W-1:0] L2_LAST_ROW = WT_ADDR_W'(N_IN - 1);
    localparam logic [WT_ADDR_W-1:0] L3_LAST_ROW = WT_ADDR_W'(WT_ROWS - 1);
    localparam logic [X_ADDR_W-1:0]  OUT_LAST    = X_ADDR_W'(N_IN - 1);

    // Layer-2 entry, one per input j
    typedef struct packed {
        fix_t w1j;                           // Weight toward z1
        fix_t w2j;                           // Weight toward z2
        fix_t b1;                            // Bias of z1, row 0 only
        fix_t b2;                            // Bias of z2, row 0 only
    } l2_row_t;

    // Layer-3 entry, one per output j
    typedef struct packed {
        fix_t wj1;                           // Weight from z1
        fix_t wj2;                           // Weight from z2
        fix_t bj;
        fix_t pad;                           // Unused low field
    } l3_row_t;

    // Same 64-bit word, decoded by row range
    typedef union packed {
        l2_row_t l2;
        l3_row_t l3;
    } wt_row_u;

    // Host write port of the weight memory
    typedef struct packed {
        logic                 en;
        logic [WT_BE_W-1:0]   be;
        logic [WT_ADDR_W-1:0] addr;
        wt_row_u              data;
    } wt_wr_t;

    // Host write port of the input memory
    typedef struct packed {
        logic                en;
        logic [X_BE_W-1:0]   be;
        logic [X_ADDR_W-1:0] addr;
        fix_t                data;
    } x_wr_t;

    typedef struct packed {
        fix_t z1;
        fix_t z2;
    } lat_t;

endpackage

`default_nettype wire

// ==== src/param_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port RAM, byte write enables, registered read
module param_ram #(
    parameter int DATA_W = 16,
    parameter int DEPTH  = 16,
    parameter int ADDR_W = 4,
    parameter int BE_W   = 2                 // DATA_W / 8
) (
    input  wire              clk,
    input  wire              wr_en,
    input  wire [BE_W-1:0]   wr_be,
    input  wire [ADDR_W-1:0] wr_addr,
    input  wire [DATA_W-1:0] wr_data,
    input  wire              rd_en,
    input  wire [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [DEPTH];          // Storage array

    // Write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (wr_be[b])
                begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];   // Only enabled bytes
                end
            end
        end
    end

    // Read port, output holds while rd_en is low
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/vae_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Run controller
// One row counter plus a phase register drive every read and strobe
module vae_sequencer (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           start,
    output logic                          idle,
    output logic                          done,
    output logic                          wt_rd_en,
    output logic [vae_pkg::WT_ADDR_W-1:0] wt_rd_addr,
    output logic                          x_rd_en,
    output logic [vae_pkg::X_ADDR_W-1:0]  x_rd_addr,
    output logic                          l2_step,
    output logic                          l2_first,
    output logic                          lat_ready,
    output logic                          l3_step,
    input  wire                           out_wr_valid,
    output logic [vae_pkg::X_ADDR_W-1:0]  out_wr_addr
);

    enum logic [2:0] {
        PH_IDLE,                             // Waiting for start
        PH_L2,                               // Rows 0..8 with inputs 0..8
        PH_WAIT,                             // Latents settle
        PH_L3,                               // Rows 9..17
        PH_DRAIN                             // Decoder pipeline empties
    } phase;

    logic [vae_pkg::WT_ADDR_W-1:0] cnt;      // Weight row now being read
    logic [vae_pkg::X_ADDR_W-1:0]  wr_cnt;   // Outputs written so far
    logic                          last_wr;  // Ninth output write

    assign last_wr = out_wr_valid && (wr_cnt == vae_pkg::OUT_LAST);

    // Phase and row counter
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase <= PH_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (phase)
                PH_IDLE:
                begin
                    if (start)                   // Ignored outside idle
                    begin
                        phase <= PH_L2;
                        cnt   <= '0;
                    end
                end
                PH_L2:
                begin
                    if (cnt == vae_pkg::L2_LAST_ROW)
                    begin
                        phase <= PH_WAIT;
                        cnt   <= vae_pkg::L3_BASE;   // Parked for layer 3
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PH_WAIT:
                begin
                    phase <= PH_L3;              // One bubble for lat_ready
                end
                PH_L3:
                begin
                    if (cnt == vae_pkg::L3_LAST_ROW)
                    begin
                        phase <= PH_DRAIN;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PH_DRAIN:
                begin
                    if (last_wr)
                    begin
                        phase <= PH_IDLE;        // idle rises with done
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // Output write address
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_cnt <= '0;
        end
        else if ((phase == PH_IDLE) && start)
        begin
            wr_cnt <= '0;                        // New run
        end
        else if (out_wr_valid)
        begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // Stage strobes, one cycle behind the reads they belong to
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            l2_step   <= 1'b0;
            l2_first  <= 1'b0;
            lat_ready <= 1'b0;
            l3_step   <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            l2_step   <= (phase == PH_L2);
            l2_first  <= (phase == PH_L2) && (cnt == '0);
            lat_ready <= (phase == PH_WAIT);     // After the last l2_step
            l3_step   <= (phase == PH_L3);
            done      <= (phase == PH_DRAIN) && last_wr;   // Single pulse
        end
    end

    assign idle        = (phase == PH_IDLE);
    assign wt_rd_en    = (phase == PH_L2) || (phase == PH_L3);
    assign wt_rd_addr  = cnt;
    assign x_rd_en     = (phase == PH_L2);
    assign x_rd_addr   = cnt[vae_pkg::X_ADDR_W-1:0];   // Rows 0..8 map onto inputs
    assign out_wr_addr = wr_cnt;

endmodule

`default_nettype wire

// ==== src/latent_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

// Layer-2 mean branch
// Nine products per latent accumulated one input per step
module latent_mac (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    l2_step,
    input  wire                    l2_first,
    input  wire                    lat_ready,
    input  wire vae_pkg::fix_t     x,
    input  wire vae_pkg::l2_row_t  row,
    output vae_pkg::lat_t          lat
);

    vae_pkg::fix_t w     [vae_pkg::N_LAT];   // Weights of this step
    vae_pkg::acc_t prod  [vae_pkg::N_LAT];
    vae_pkg::acc_t acc   [vae_pkg::N_LAT];
    vae_pkg::fix_t bias  [vae_pkg::N_LAT];   // Held from row 0
    vae_pkg::acc_t sum   [vae_pkg::N_LAT];   // Accumulator plus shifted bias
    vae_pkg::fix_t trunc [vae_pkg::N_LAT];

    assign w[0] = row.w1j;
    assign w[1] = row.w2j;

    always_comb
    begin
        for (int i = 0; i < vae_pkg::N_LAT; i++)
        begin
            prod[i]  = x * w[i];                 // Full 32-bit product
            sum[i]   = acc[i] + (vae_pkg::acc_t'(bias[i]) <<< vae_pkg::FRAC_BITS);
            trunc[i] = sum[i][vae_pkg::FRAC_BITS +: $bits(vae_pkg::fix_t)];   // Bits 23:8
        end
    end

    // Biases only live in row 0
    always_ff @(posedge clk)
    begin
        if (l2_step && l2_first)
        begin
            bias[0] <= row.b1;
            bias[1] <= row.b2;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < vae_pkg::N_LAT; i++)
            begin
                acc[i] <= '0;
            end
            lat <= '0;
        end
        else
        begin
            if (l2_step)
            begin
                for (int i = 0; i < vae_pkg::N_LAT; i++)
                begin
                    acc[i] <= l2_first ? prod[i] : acc[i] + prod[i];   // Reload on first
                end
            end
            if (lat_ready)
            begin
                lat.z1 <= trunc[0];
                lat.z2 <= trunc[1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/decoder_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

// Layer-3 branch, two register stages
// One decoded output per row, ReLU on the truncated sum
module decoder_mac (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    l3_step,
    input  wire vae_pkg::lat_t     lat,
    input  wire vae_pkg::l3_row_t  row,
    output logic                   o_valid,
    output vae_pkg::fix_t          o_data
);

    // Stage one
    vae_pkg::acc_t p1;                       // z1 * wj1
    vae_pkg::acc_t p2;                       // z2 * wj2
    vae_pkg::acc_t pb;                       // Bias aligned to the products
    logic          v1;

    // Stage two inputs
    vae_pkg::acc_t sum;
    vae_pkg::fix_t trunc;
    vae_pkg::fix_t relu;

    assign sum   = p1 + p2 + pb;
    assign trunc = sum[vae_pkg::FRAC_BITS +: $bits(vae_pkg::fix_t)];
    assign relu  = trunc[$bits(vae_pkg::fix_t)-1] ? '0 : trunc;   // Clamp negatives

    always_ff @(posedge clk)
    begin
        if (l3_step)
        begin
            p1 <= lat.z1 * row.wj1;
            p2 <= lat.z2 * row.wj2;
            pb <= vae_pkg::acc_t'(row.bj) <<< vae_pkg::FRAC_BITS;
        end
    end

    always_ff @(posedge clk)
    begin
        if (v1)
        begin
            o_data <= relu;
        end
    end

    // Valid pipeline, o_valid two cycles after l3_step
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            v1      <= 1'b0;
            o_valid <= 1'b0;
        end
        else
        begin
            v1      <= l3_step;
            o_valid <= v1;
        end
    end

endmodule

`default_nettype wire

// ==== src/forward_vae_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

// VAE forward pass, mean path only
// Host loads weights and inputs, pulses start, reads outputs after done
module forward_vae_bram (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    output logic                         idle,
    output logic                         done,
    input  wire vae_pkg::wt_wr_t         wt_wr,
    input  wire vae_pkg::x_wr_t          x_wr,
    input  wire                          out_rd_en,
    input  wire [vae_pkg::X_ADDR_W-1:0]  out_rd_addr,
    output vae_pkg::fix_t                out_rd_data
);

    logic                          wt_rd_en;
    logic [vae_pkg::WT_ADDR_W-1:0] wt_rd_addr;
    vae_pkg::wt_row_u              wt_rd_data;   // Decoded per layer below
    logic                          x_rd_en;
    logic [vae_pkg::X_ADDR_W-1:0]  x_rd_addr;
    vae_pkg::fix_t                 x_rd_data;
    logic                          l2_step;
    logic                          l2_first;
    logic                          lat_ready;
    logic                          l3_step;
    vae_pkg::lat_t                 lat;
    logic                          o_valid;
    vae_pkg::fix_t                 o_data;
    logic [vae_pkg::X_ADDR_W-1:0]  out_wr_addr;

    // Weight memory, both layers
    param_ram #(
        .DATA_W ($bits(vae_pkg::wt_row_u)),
        .DEPTH  (vae_pkg::WT_ROWS),
        .ADDR_W (vae_pkg::WT_ADDR_W),
        .BE_W   (vae_pkg::WT_BE_W)
    ) u_wt_ram (
        .clk     (clk),
        .wr_en   (wt_wr.en),
        .wr_be   (wt_wr.be),
        .wr_addr (wt_wr.addr),
        .wr_data (wt_wr.data),
        .rd_en   (wt_rd_en),
        .rd_addr (wt_rd_addr),
        .rd_data (wt_rd_data)
    );

    // Input samples
    param_ram #(
        .DATA_W ($bits(vae_pkg::fix_t)),
        .DEPTH  (vae_pkg::N_IN),
        .ADDR_W (vae_pkg::X_ADDR_W),
        .BE_W   (vae_pkg::X_BE_W)
    ) u_x_ram (
        .clk     (clk),
        .wr_en   (x_wr.en),
        .wr_be   (x_wr.be),
        .wr_addr (x_wr.addr),
        .wr_data (x_wr.data),
        .rd_en   (x_rd_en),
        .rd_addr (x_rd_addr),
        .rd_data (x_rd_data)
    );

    // Decoded outputs, written whole words by the decoder
    param_ram #(
        .DATA_W ($bits(vae_pkg::fix_t)),
        .DEPTH  (vae_pkg::N_IN),
        .ADDR_W (vae_pkg::X_ADDR_W),
        .BE_W   (vae_pkg::X_BE_W)
    ) u_out_ram (
        .clk     (clk),
        .wr_en   (o_valid),
        .wr_be   ({vae_pkg::X_BE_W{1'b1}}),
        .wr_addr (out_wr_addr),
        .wr_data (o_data),
        .rd_en   (out_rd_en),
        .rd_addr (out_rd_addr),
        .rd_data (out_rd_data)
    );

    vae_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .idle         (idle),
        .done         (done),
        .wt_rd_en     (wt_rd_en),
        .wt_rd_addr   (wt_rd_addr),
        .x_rd_en      (x_rd_en),
        .x_rd_addr    (x_rd_addr),
        .l2_step      (l2_step),
        .l2_first     (l2_first),
        .lat_ready    (lat_ready),
        .l3_step      (l3_step),
        .out_wr_valid (o_valid),
        .out_wr_addr  (out_wr_addr)
    );

    latent_mac u_lat (
        .clk       (clk),
        .rst_n     (rst_n),
        .l2_step   (l2_step),
        .l2_first  (l2_first),
        .lat_ready (lat_ready),
        .x         (x_rd_data),
        .row       (wt_rd_data.l2),          // Rows 0..8 view
        .lat       (lat)
    );

    decoder_mac u_dec (
        .clk     (clk),
        .rst_n   (rst_n),
        .l3_step (l3_step),
        .lat     (lat),
        .row     (wt_rd_data.l3),            // Rows 9..17 view
        .o_valid (o_valid),
        .o_data  (o_data)
    );

endmodule

`default_nettype wire

// ==== tb/vae_tests.svh ====
`ifndef VAE_TESTS_SVH
`define VAE_TESTS_SVH

// Q8.8 within +-2.0
function automatic vae_pkg::fix_t rand_fix();
    return vae_pkg::fix_t'(int'($urandom_range(1024, 0)) - 512);
endfunction

function automatic vae_pkg::wt_row_u rand_row();
    return {rand_fix(), rand_fix(), rand_fix(), rand_fix()};
endfunction

// One host write, shadow merged by byte enables
task automatic write_wt(input int addr, input vae_pkg::wt_row_u data,
                        input logic [vae_pkg::WT_BE_W-1:0] be);
    @(negedge clk);
    wt_wr.en   = 1'b1;
    wt_wr.be   = be;
    wt_wr.addr = vae_pkg::WT_ADDR_W'(addr);
    wt_wr.data = data;
    @(negedge clk);
    wt_wr.en     = 1'b0;
    wt_img[addr] = merge_bytes(wt_img[addr], data, be);
endtask

task automatic write_x(input int addr, input vae_pkg::fix_t data,
                       input logic [vae_pkg::X_BE_W-1:0] be);
    logic [63:0] merged;
    @(negedge clk);
    x_wr.en   = 1'b1;
    x_wr.be   = be;
    x_wr.addr = vae_pkg::X_ADDR_W'(addr);
    x_wr.data = data;
    @(negedge clk);
    x_wr.en     = 1'b0;
    merged      = merge_bytes({48'h0, x_img[addr]}, {48'h0, data}, {6'h0, be});
    x_img[addr] = merged[15:0];
endtask

task automatic load_random();
    for (int a = 0; a < vae_pkg::WT_ROWS; a++)
        write_wt(a, rand_row(), '1);
    for (int a = 0; a < vae_pkg::N_IN; a++)
        write_x(a, rand_fix(), '1);
endtask

// Pulse start, optionally again while busy, then wait for done
task automatic run_once(input logic extra_start);
    int   n_done;
    int   cyc;
    logic seen;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_bit("idle", idle, 1'b0);
    if (extra_start)
    begin
        repeat (3) @(negedge clk);
        start = 1'b1;                        // Sequencer is busy here
        @(negedge clk);
        start = 1'b0;
    end
    n_done = 0;
    cyc    = 0;
    seen   = 1'b0;
    while (!seen && cyc < RUN_LIMIT)
    begin
        @(negedge clk);
        cyc++;
        if (done)
        begin
            seen = 1'b1;
            n_done++;
            check_bit("idle", idle, 1'b1);   // idle rises with done
        end
    end
    if (!seen)
    begin
        timed_out = 1'b1;
        errors++;
        $display("Timeout: done never came within %0d cycles", RUN_LIMIT);
    end
    else
    begin
        repeat (QUIET_CYCLES)
        begin
            @(negedge clk);
            if (done)
                n_done++;
        end
        check_bit("idle", idle, 1'b1);
        check_bit("done", done, 1'b0);
        if (n_done != 1)
        begin
            errors++;
            $display("Expected one done pulse for the run but saw %0d", n_done);
        end
    end
endtask

// Read one output word, valid one cycle after the request
task automatic read_out(input int addr, output vae_pkg::fix_t data);
    @(negedge clk);
    out_rd_en   = 1'b1;
    out_rd_addr = vae_pkg::X_ADDR_W'(addr);
    @(negedge clk);
    out_rd_en = 1'b0;
    data      = out_rd_data;
endtask

task automatic check_outputs();
    vae_pkg::fix_t got;
    for (int j = 0; j < vae_pkg::N_IN; j++)
    begin
        read_out(j, got);
        check_fix($sformatf("out_rd_data[%0d]", j), got, model_out(j));
    end
endtask

task automatic after_reset();
    open_test();
    check_bit("idle", idle, 1'b1);
    check_bit("done", done, 1'b0);
    close_test("after_reset");
endtask

// x0 = 1.0 only; z1 = 1.25, z2 = 0.5; out j = 1.75 + 0.25 j
task automatic identity_load();
    vae_pkg::wt_row_u r;
    vae_pkg::fix_t    got;
    open_test();
    for (int a = 0; a < vae_pkg::N_IN; a++)
    begin
        r        = '0;
        r.l2.w1j = (a == 0) ? 16'sh0100 : 16'sh0080;
        r.l2.w2j = 16'sh0080;
        r.l2.b1  = (a == 0) ? 16'sh0040 : 16'sh0000;   // Only row 0 counts
        write_wt(a, r, '1);
        write_x(a, (a == 0) ? 16'sh0100 : 16'sh0000, '1);
    end
    for (int j = 0; j < vae_pkg::N_IN; j++)
    begin
        r        = '0;
        r.l3.wj1 = 16'sh0100;
        r.l3.wj2 = 16'sh0100;
        r.l3.bj  = vae_pkg::fix_t'(64 * j);
        write_wt(vae_pkg::N_IN + j, r, '1);
    end
    run_once(1'b0);
    for (int j = 0; j < vae_pkg::N_IN && !timed_out; j++)
    begin
        read_out(j, got);
        check_fix($sformatf("out_rd_data[%0d]", j), got,
                  vae_pkg::fix_t'(16'h01C0 + 64 * j));
    end
    close_test("identity_load");
endtask

// Even outputs get -1.0 on z1, so ReLU clamps them
task automatic relu_clamp();
    vae_pkg::wt_row_u r;
    vae_pkg::fix_t    got;
    open_test();
    for (int j = 0; j < vae_pkg::N_IN; j += 2)
    begin
        r        = '0;
        r.l3.wj1 = 16'shFF00;
        write_wt(vae_pkg::N_IN + j, r, '1);
    end
    run_once(1'b0);
    for (int j = 0; j < vae_pkg::N_IN && !timed_out; j++)
    begin
        read_out(j, got);
        if (j % 2 == 0)
            check_fix($sformatf("out_rd_data[%0d]", j), got, 16'sh0000);
        else
            check_fix($sformatf("out_rd_data[%0d]", j), got, model_out(j));
    end
    close_test("relu_clamp");
endtask

task automatic random_runs();
    open_test();
    for (int k = 0; k < 3 && !timed_out; k++)
    begin
        load_random();
        run_once(1'b0);
        if (!timed_out)
            check_outputs();
    end
    close_test("random_runs");
endtask

task automatic busy_start();
    open_test();
    load_random();
    run_once(1'b1);
    if (!timed_out)
        check_outputs();
    close_test("busy_start");
endtask

// Low byte of each field on odd rows, low byte of even inputs
task automatic byte_enables();
    open_test();
    for (int a = 1; a < vae_pkg::WT_ROWS; a += 2)
        write_wt(a, rand_row(), 8'h55);
    for (int a = 0; a < vae_pkg::N_IN; a += 2)
        write_x(a, rand_fix(), 2'b01);
    run_once(1'b0);
    if (!timed_out)
        check_outputs();
    close_test("byte_enables");
endtask

`endif

// ==== tb/tb_forward_vae_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_forward_vae_bram;

    localparam int RUN_LIMIT    = 100;       // Cycles allowed from start to done
    localparam int QUIET_CYCLES = 40;        // Watch window for a stray second done

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    logic                         idle;
    logic                         done;
    vae_pkg::wt_wr_t              wt_wr;
    vae_pkg::x_wr_t               x_wr;
    logic                         out_rd_en;
    logic [vae_pkg::X_ADDR_W-1:0] out_rd_addr;
    vae_pkg::fix_t                out_rd_data;

    vae_pkg::wt_row_u wt_img [vae_pkg::WT_ROWS];   // Shadow of the weight memory
    vae_pkg::fix_t    x_img  [vae_pkg::N_IN];      // Shadow of the input memory
    int               errors;
    int               errs_at_open;              // Error count when a test began
    int               tests_run;
    int               tests_failed;
    logic             timed_out;

    forward_vae_bram u_forward_vae_bram (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .idle        (idle),
        .done        (done),
        .wt_wr       (wt_wr),
        .x_wr        (x_wr),
        .out_rd_en   (out_rd_en),
        .out_rd_addr (out_rd_addr),
        .out_rd_data (out_rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;               // 4 ns period
    end

    task automatic check_fix(input string name, input vae_pkg::fix_t got,
                             input vae_pkg::fix_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %s got 0x%04h expected 0x%04h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %s got 0x%01h expected 0x%01h", name, got, exp);
        end
    endtask

    // Byte-wise merge, same rule as a byte-enabled write
    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  be);
        logic [63:0] res;
        res = old_word;
        for (int b = 0; b < 8; b++)
        begin
            if (be[b])
                res[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return res;
    endfunction

    // Latent i from the shadow arrays, bias from row 0
    function automatic vae_pkg::fix_t model_latent(input int i);
        vae_pkg::acc_t acc;
        vae_pkg::fix_t w;
        vae_pkg::fix_t b;
        acc = 0;
        for (int j = 0; j < vae_pkg::N_IN; j++)
        begin
            w = (i == 0) ? wt_img[j].l2.w1j : wt_img[j].l2.w2j;
            acc += vae_pkg::acc_t'(x_img[j]) * vae_pkg::acc_t'(w);
        end
        b = (i == 0) ? wt_img[0].l2.b1 : wt_img[0].l2.b2;
        acc += vae_pkg::acc_t'(b) * 256;     // Bias in accumulator scale
        return vae_pkg::fix_t'(acc >>> vae_pkg::FRAC_BITS);
    endfunction

    // Decoded output j, then ReLU
    function automatic vae_pkg::fix_t model_out(input int j);
        vae_pkg::fix_t   z1;
        vae_pkg::fix_t   z2;
        vae_pkg::l3_row_t row;
        vae_pkg::acc_t   acc;
        vae_pkg::fix_t   res;
        z1  = model_latent(0);
        z2  = model_latent(1);
        row = wt_img[vae_pkg::N_IN + j].l3;  // Layer-3 rows follow layer 2
        acc = vae_pkg::acc_t'(z1) * vae_pkg::acc_t'(row.wj1)
            + vae_pkg::acc_t'(z2) * vae_pkg::acc_t'(row.wj2)
            + vae_pkg::acc_t'(row.bj) * 256;
        res = vae_pkg::fix_t'(acc >>> vae_pkg::FRAC_BITS);
        return (res < 0) ? vae_pkg::fix_t'(0) : res;
    endfunction

    task automatic open_test();
        errs_at_open = errors;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors > errs_at_open)
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_at_open);
        end
        else
            $display("%s: ok", name);
    endtask

    `include "vae_tests.svh"

    initial
    begin
        void'($urandom(32'ha4a9337d));
        errors       = 0;
        errs_at_open = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        wt_wr        = '0;
        x_wr         = '0;
        out_rd_en    = 1'b0;
        out_rd_addr  = '0;
        repeat (3) @(negedge clk);           // Reset held 3 cycles
        rst_n = 1'b1;

        after_reset();
        if (!timed_out) identity_load();
        if (!timed_out) relu_clamp();
        if (!timed_out) random_runs();
        if (!timed_out) busy_start();
        if (!timed_out) byte_enables();

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== forward_vae_bram.f ====
+incdir+tb
src/vae_pkg.sv
src/param_ram.sv
src/vae_sequencer.sv
src/latent_mac.sv
src/decoder_mac.sv
src/forward_vae_bram.sv
tb/tb_forward_vae_bram.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the forward_vae_bram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_forward_vae_bram \
    -f forward_vae_bram.f

out=$(./obj_dir/Vtb_forward_vae_bram)
printf '%s\n' "$out"

# Non-zero exit when the pass line is missing
printf '%s\n' "$out" | grep -qx "TEST PASS"
